/* flist.f */
hdl/cordic_pkg.sv
hdl/angle_to_fixed.sv
hdl/cordic_rotator.sv
hdl/leading_one_detector.sv
hdl/fixed_to_float.sv
hdl/cos_unit.sv
bench/cos_unit_chk.sv
bench/cos_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the cos_unit testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cos_unit_tb -f flist.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vcos_unit_tb | tee /dev/stderr | grep -qF ">>> PASS" \
    && echo "Simulation finished without errors" \
    || { echo "Simulation reported errors"; exit 1; }

/* bench/cos_unit_tb.sv */
`default_nettype none

module cos_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int  iterations    = 16;
    // Operations in the sequence, idle and stall periods counted as extra ones
    localparam int  test_ops      = 32;
    localparam int  timeout_limit = test_ops * (iterations + 4) + 100;
    localparam int  random_count  = 20;
    localparam int  stall_cycles  = 6;
    // Residual angle after the last step can reach atan(2^-15), about 3.05e-5
    localparam real tolerance     = 3.0e-5;

    logic                              clock;
    logic                              arst_n;
    logic                              clk_en;
    logic                              start;
    logic [cordic_pkg::word_width-1:0] dataa;
    logic [cordic_pkg::word_width-1:0] result;
    logic                              done;

    integer seed;
    int     errors;
    int     errors_at_test_start;
    int     tests_passed;
    int     tests_failed;
    int     cycle_count;

    cos_unit #(
        .ITERATIONS (iterations)
    ) cos_unit_inst (
        .clock  (clock),
        .arst_n (arst_n),
        .clk_en (clk_en),
        .start  (start),
        .dataa  (dataa),
        .result (result),
        .done   (done)
    );

    bind cos_unit cos_unit_chk #(
        .ITERATIONS (ITERATIONS)
    ) cos_unit_chk_inst (
        .clock  (clock),
        .arst_n (arst_n),
        .clk_en (clk_en),
        .start  (start),
        .result (result),
        .done   (done)
    );

    always #5 clock = ~clock;

    // ------------------------------
    // Float helpers
    // ------------------------------
    function automatic real float_to_real(input cordic_pkg::fp_word_t word);
        real mag;
        int  scale;
        if (word.fields.exponent == 8'd0) begin
            mag   = real'(word.fields.mantissa) / 8388608.0;
            scale = 1 - cordic_pkg::fp_bias;
        end else begin
            mag   = 1.0 + real'(word.fields.mantissa) / 8388608.0;
            scale = int'(word.fields.exponent) - cordic_pkg::fp_bias;
        end
        while (scale > 0) begin
            mag   = mag * 2.0;
            scale = scale - 1;
        end
        while (scale < 0) begin
            mag   = mag / 2.0;
            scale = scale + 1;
        end
        return word.fields.sign ? -mag : mag;
    endfunction

    // Positive values below 1.0 only
    function automatic cordic_pkg::fp_word_t real_to_float(input real value);
        cordic_pkg::fp_word_t word;
        real                  mag;
        int                   exp_field;
        word      = '0;
        mag       = value;
        exp_field = cordic_pkg::fp_bias;
        if (mag > 0.0) begin
            while (mag < 1.0 && exp_field > 1) begin
                mag       = mag * 2.0;
                exp_field = exp_field - 1;
            end
            word.fields.exponent = 8'(exp_field);
            word.fields.mantissa = 23'($rtoi((mag - 1.0) * 8388608.0));
        end
        return word;
    endfunction

    // ------------------------------
    // Checks and bookkeeping
    // ------------------------------
    task automatic check_value(input string name, input cordic_pkg::fp_word_t got,
                               input real expected);
        real got_real;
        real diff;
        got_real = float_to_real(got);
        diff     = got_real - expected;
        if (diff < 0.0) begin
            diff = -diff;
        end
        assert (diff <= tolerance) else begin
            $display("FAIL t=%0t %s: got %0.9f expected %0.9f", $time, name, got_real,
                     expected);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else begin
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic begin_test();
        errors_at_test_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_test_start) begin
            tests_passed++;
            $display("Test %-14s passed", name);
        end else begin
            tests_failed++;
            $display("Test %-14s failed with %0d errors", name, errors - errors_at_test_start);
        end
    endtask

    task automatic finish_run();
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // ------------------------------
    // Operation helpers
    // ------------------------------
    // Returns right after the edge that accepts start
    task automatic issue_start(input cordic_pkg::fp_word_t angle_word);
        @(posedge clock);
        dataa  <= angle_word.bits;
        start  <= 1'b1;
        clk_en <= 1'b1;
        @(posedge clock);
        start  <= 1'b0;
    endtask

    // Counts rising edges until done is seen high at a falling edge
    task automatic wait_for_done(output int cycles);
        cycles = 0;
        @(negedge clock);
        while (!done) begin
            @(posedge clock);
            cycles++;
            @(negedge clock);
        end
    endtask

    task automatic run_and_check(input cordic_pkg::fp_word_t angle_word,
                                 output cordic_pkg::fp_word_t word);
        int cycles;
        issue_start(angle_word);
        wait_for_done(cycles);
        word = result;
        check_count("done latency", cycles, iterations);
        check_count("result sign", int'(word.fields.sign), 0);
        check_value("result", word, $cos(float_to_real(angle_word)));
    endtask

    // Timeout watchdog
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            errors++;
            finish_run();
        end
    end

    initial begin
        int                   cycles;
        logic [31:0]          raw;
        real                  angle;
        cordic_pkg::fp_word_t angle_word;
        cordic_pkg::fp_word_t negated;
        cordic_pkg::fp_word_t word_a;
        cordic_pkg::fp_word_t word_b;

        clock        = 1'b0;
        arst_n       = 1'b0;
        clk_en       = 1'b0;
        start        = 1'b0;
        dataa        = '0;
        seed         = 32'h09df_81c8;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count  = 0;

        repeat (10) @(posedge clock);
        arst_n <= 1'b1;

        // Idle after reset, frozen first and then enabled without a start
        begin_test();
        repeat (4) begin
            @(negedge clock);
            check_count("done", int'(done), 0);
        end
        @(posedge clock);
        clk_en <= 1'b1;
        repeat (iterations + 4) begin
            @(negedge clock);
            check_count("done", int'(done), 0);
        end
        end_test("after_reset");

        // Zero and subnormal
        begin_test();
        run_and_check(32'h0000_0000, word_a);
        run_and_check(32'h0000_1234, word_b);
        check_word("result", word_b, word_a);
        end_test("zero_exponent");

        begin_test();
        angle_word = real_to_float(0.6);
        negated    = angle_word;
        negated.fields.sign = 1'b1;
        run_and_check(angle_word, word_a);
        run_and_check(negated, word_b);
        check_word("result", word_b, word_a);
        end_test("sign_ignored");

        begin_test();
        for (int i = 0; i < random_count; i++) begin
            raw   = $random(seed);
            angle = real'(raw & 32'h7fff_ffff) / 2147483648.0 * 0.99;
            run_and_check(real_to_float(angle), word_a);
        end
        end_test("random_angles");

        // Stall mid-operation, then compare with the uninterrupted run
        begin_test();
        angle_word = real_to_float(0.85);
        run_and_check(angle_word, word_a);
        issue_start(angle_word);
        repeat (5) @(posedge clock);
        clk_en <= 1'b0;
        repeat (stall_cycles) @(posedge clock);
        clk_en <= 1'b1;
        wait_for_done(cycles);
        check_count("done latency", cycles + 5 + stall_cycles, iterations + stall_cycles);
        word_b = result;
        check_word("result", word_b, word_a);
        // Start while frozen must be ignored
        @(posedge clock);
        clk_en <= 1'b0;
        start  <= 1'b1;
        dataa  <= real_to_float(0.2);
        repeat (3) @(posedge clock);
        start  <= 1'b0;
        @(negedge clock);
        check_count("done", int'(done), 1);
        check_word("result", result, word_a);
        end_test("clk_en_stall");

        begin_test();
        issue_start(real_to_float(0.3));
        repeat (6) @(posedge clock);
        run_and_check(real_to_float(0.7), word_a);
        end_test("restart");

        finish_run();
    end

endmodule

`default_nettype wire

/* bench/cos_unit_chk.sv */
`default_nettype none

module cos_unit_chk #(
    parameter int ITERATIONS = 16
) (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              clk_en,
    input  logic                              start,
    input  logic [cordic_pkg::word_width-1:0] result,
    input  logic                              done
);

    timeunit 1ns;
    timeprecision 1ps;

    // Enabled edges since the last accepted start, saturating
    int   steps;
    logic seen_start;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            steps      <= 0;
            seen_start <= 1'b0;
        end else if (clk_en) begin
            if (start) begin
                steps      <= 0;
                seen_start <= 1'b1;
            end else if (seen_start && steps < ITERATIONS) begin
                steps <= steps + 1;
            end
        end
    end

    // ------------------------------
    // Done timing
    // ------------------------------
    a_done_low_before_start: assert property (
        @(posedge clock) disable iff (!arst_n)
        !seen_start |-> !done
    ) else $error("done is high before any accepted start");

    a_done_low_while_running: assert property (
        @(posedge clock) disable iff (!arst_n)
        (seen_start && steps < ITERATIONS) |-> !done
    ) else $error("done is high after only %0d enabled cycles", steps);

    a_done_high_at_count: assert property (
        @(posedge clock) disable iff (!arst_n)
        (seen_start && steps == ITERATIONS) |-> done
    ) else $error("done is still low after %0d enabled cycles", steps);

    // ------------------------------
    // Freeze and output format
    // ------------------------------
    a_hold_when_frozen: assert property (
        @(posedge clock) disable iff (!arst_n)
        !clk_en |=> ($stable(result) && $stable(done))
    ) else $error("result or done changed on an edge with clk_en low");

    // Cosine of an angle below 1.0 is positive
    a_sign_clear_when_done: assert property (
        @(posedge clock) disable iff (!arst_n)
        done |-> !result[cordic_pkg::word_width-1]
    ) else $error("result sign bit set while done is high");

endmodule

`default_nettype wire

/* hdl/cos_unit.sv */
`default_nettype none

module cos_unit #(
    parameter int ITERATIONS = 16
) (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              clk_en,
    input  logic                              start,
    input  logic [cordic_pkg::word_width-1:0] dataa,
    output logic [cordic_pkg::word_width-1:0] result,
    output logic                              done
);

    logic [cordic_pkg::word_width-1:0] fixed_angle;
    logic [cordic_pkg::word_width-1:0] cos_fixed;
    logic [4:0]                        lead_count;
    logic                              any_one;

    // Table has only max_iterations entries
    if (ITERATIONS < 1 || ITERATIONS > cordic_pkg::max_iterations) begin : g_bad_iterations
        $error("cos_unit: ITERATIONS must lie in 1..%0d", cordic_pkg::max_iterations);
    end

    // ------------------------------
    // Float in, fixed out
    // ------------------------------
    angle_to_fixed angle_to_fixed_inst (
        .angle       (dataa),
        .fixed_angle (fixed_angle)
    );

    cordic_rotator #(
        .ITERATIONS (ITERATIONS)
    ) cordic_rotator_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .clk_en      (clk_en),
        .start       (start),
        .fixed_angle (fixed_angle),
        .cos_fixed   (cos_fixed),
        .done        (done)
    );

    // ------------------------------
    // Fixed in, float out
    // ------------------------------
    leading_one_detector leading_one_detector_inst (
        .value      (cos_fixed),
        .lead_count (lead_count),
        .any_one    (any_one)
    );

    fixed_to_float fixed_to_float_inst (
        .cos_fixed  (cos_fixed),
        .lead_count (lead_count),
        .any_one    (any_one),
        .result     (result)
    );

endmodule

`default_nettype wire

/* hdl/fixed_to_float.sv */
`default_nettype none

module fixed_to_float (
    input  logic [cordic_pkg::word_width-1:0] cos_fixed,
    input  logic [4:0]                        lead_count,
    input  logic                              any_one,
    output logic [cordic_pkg::word_width-1:0] result
);

    cordic_pkg::fp_word_t              float_word;
    logic [cordic_pkg::word_width-1:0] normalized;
    logic [7:0]                        exponent;

    // Leading one moved up to bit 31, the 1.0 position
    assign normalized = cos_fixed << lead_count;

    // Bit 31 of the fixed value is 2^0, so each leading zero is one step down
    assign exponent = 8'(cordic_pkg::fp_bias) - {3'b000, lead_count};

    always_comb begin
        float_word = '0;
        if (any_one) begin
            // Cosine is positive over the whole input range
            float_word.fields.sign     = 1'b0;
            float_word.fields.exponent = exponent;
            // Bits below the hidden one, truncated
            float_word.fields.mantissa = normalized[30:8];
        end
    end

    assign result = float_word.bits;

endmodule

`default_nettype wire

/* hdl/leading_one_detector.sv */
`default_nettype none

module leading_one_detector (
    input  logic [cordic_pkg::word_width-1:0] value,
    output logic [4:0]                        lead_count,
    output logic                              any_one
);

    localparam int nibbles = cordic_pkg::word_width / 4;

    logic [nibbles-1:0]      nibble_valid;
    logic [nibbles-1:0][1:0] nibble_count;
    logic [2:0]              first_nibble;

    // Leading zeros within one nibble, MSB first
    function automatic logic [1:0] nibble_zeros(input logic [3:0] bits);
        logic [1:0] count;
        count[1] = !bits[3] && !bits[2];
        count[0] = (!bits[3] && bits[2]) || (!bits[3] && !bits[1] && bits[0]);
        return count;
    endfunction

    // ------------------------------
    // First level, per nibble
    // ------------------------------
    // Nibble 0 is the most significant one, bits 31:28
    always_comb begin
        for (int n = 0; n < nibbles; n++) begin
            nibble_valid[n] = |value[cordic_pkg::word_width-1-4*n -: 4];
            nibble_count[n] = nibble_zeros(value[cordic_pkg::word_width-1-4*n -: 4]);
        end
    end

    // ------------------------------
    // Second level, across nibbles
    // ------------------------------
    // Scan from the bottom so the highest non-empty nibble is the last to write
    always_comb begin
        first_nibble = '0;
        for (int n = nibbles - 1; n >= 0; n--) begin
            if (nibble_valid[n]) begin
                first_nibble = 3'(n);
            end
        end
    end

    // Count is a don't-care when the word is zero
    assign lead_count = {first_nibble, nibble_count[first_nibble]};
    assign any_one    = |nibble_valid;

endmodule

`default_nettype wire

/* hdl/cordic_rotator.sv */
`default_nettype none

module cordic_rotator #(
    parameter int ITERATIONS = 16
) (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              clk_en,
    input  logic                              start,
    input  logic [cordic_pkg::word_width-1:0] fixed_angle,
    output logic [cordic_pkg::word_width-1:0] cos_fixed,
    output logic                              done
);

    // Index must be able to hold the saturation value itself
    localparam int index_width = $clog2(cordic_pkg::max_iterations + 1);
    localparam logic [index_width-1:0] last_index = index_width'(ITERATIONS);

    logic [index_width-1:0] index;
    logic                   armed;
    logic                   running;

    logic signed [cordic_pkg::word_width-1:0] x;
    logic signed [cordic_pkg::word_width-1:0] y;
    logic signed [cordic_pkg::word_width-1:0] z;

    logic signed [cordic_pkg::word_width-1:0] x_shifted;
    logic signed [cordic_pkg::word_width-1:0] y_shifted;
    logic signed [cordic_pkg::word_width-1:0] rotate_angle;

    logic signed [cordic_pkg::word_width-1:0] x_next;
    logic signed [cordic_pkg::word_width-1:0] y_next;
    logic signed [cordic_pkg::word_width-1:0] z_next;

    // ------------------------------
    // Micro-rotation datapath
    // ------------------------------
    // Nothing moves until the first start after reset
    assign running = armed && (index != last_index);

    // Low four bits are enough, the table is never read at index 16
    assign rotate_angle = signed'(cordic_pkg::atan_entry(index[3:0]));

    assign x_shifted = x >>> index;
    assign y_shifted = y >>> index;

    always_comb begin
        if (z[cordic_pkg::word_width-1]) begin
            // Residual angle negative, rotate clockwise
            x_next = x + y_shifted;
            y_next = y - x_shifted;
            z_next = z + rotate_angle;
        end else begin
            x_next = x - y_shifted;
            y_next = y + x_shifted;
            z_next = z - rotate_angle;
        end
    end

    // ------------------------------
    // State registers
    // ------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            index <= '0;
            armed <= 1'b0;
            x     <= signed'(cordic_pkg::cordic_gain_init);
            y     <= '0;
            z     <= '0;
        end else if (clk_en) begin
            if (start) begin
                // A new start always wins, even over a running operation
                index <= '0;
                armed <= 1'b1;
                x     <= signed'(cordic_pkg::cordic_gain_init);
                y     <= '0;
                z     <= signed'(fixed_angle);
            end else if (running) begin
                index <= index + 1'b1;
                x     <= x_next;
                y     <= y_next;
                z     <= z_next;
            end
        end
    end

    // x converges to cos(angle) since the gain is folded into its start value
    assign cos_fixed = x;

    // Index saturates here, so done holds until the next start
    assign done = (index == last_index);

endmodule

`default_nettype wire

/* hdl/angle_to_fixed.sv */
`default_nettype none

module angle_to_fixed (
    input  logic [cordic_pkg::word_width-1:0] angle,
    output logic [cordic_pkg::word_width-1:0] fixed_angle
);

    cordic_pkg::fp_word_t              angle_word;
    logic [cordic_pkg::word_width-1:0] aligned;
    logic [8:0]                        shift_amount;

    assign angle_word = angle;

    // Hidden one lands on bit 31, which carries weight 1.0
    assign aligned = {1'b1, angle_word.fields.mantissa, 8'b0};

    // Exponents above the bias wrap to a large shift, outside the valid range anyway
    assign shift_amount = 9'(cordic_pkg::fp_bias) - {1'b0, angle_word.fields.exponent};

    // Sign bit is never read, cos(-a) == cos(a)
    always_comb begin
        if (angle_word.fields.exponent == 8'd0) begin
            // Zero and subnormals both collapse to 0 rad
            fixed_angle = '0;
        end else if (shift_amount >= 9'd32) begin
            fixed_angle = '0;
        end else begin
            fixed_angle = aligned >> shift_amount[4:0];
        end
    end

endmodule

`default_nettype wire

/* hdl/cordic_pkg.sv */
`default_nettype none

package cordic_pkg;

    // ------------------------------
    // Word and format constants
    // ------------------------------
    localparam int word_width = 32;

    // Single-precision exponent bias
    localparam int fp_bias = 127;

    // Number of entries in the arctangent table
    localparam int max_iterations = 16;

    // Start value of x: 1/K, about 0.6073, in Q1.31
    localparam logic [word_width-1:0] cordic_gain_init = 32'h4DBA_76D4;

    // Same word seen as raw bits or as IEEE-754 fields
    typedef union packed {
        logic [word_width-1:0] bits;
        struct packed {
            logic        sign;
            logic [7:0]  exponent;
            logic [22:0] mantissa;
        } fields;
    } fp_word_t;

    // ------------------------------
    // atan(2^-i) in Q1.31
    // ------------------------------
    function automatic logic [word_width-1:0] atan_entry(input logic [3:0] index);
        logic [word_width-1:0] angle;
        case (index)
            4'd0:    angle = 32'h6487_ED51;
            4'd1:    angle = 32'h3B58_CE0A;
            4'd2:    angle = 32'h1F5B_75F9;
            4'd3:    angle = 32'h0FEA_DD4D;
            4'd4:    angle = 32'h07FD_56ED;
            4'd5:    angle = 32'h03FF_AAB7;
            4'd6:    angle = 32'h01FF_F555;
            4'd7:    angle = 32'h00FF_FEAA;
            4'd8:    angle = 32'h007F_FFD5;
            4'd9:    angle = 32'h003F_FFFA;
            4'd10:   angle = 32'h001F_FFFF;
            4'd11:   angle = 32'h000F_FFFF;
            4'd12:   angle = 32'h0007_FFFF;
            4'd13:   angle = 32'h0003_FFFF;
            4'd14:   angle = 32'h0001_FFFF;
            default: angle = 32'h0000_FFFF;
        endcase
        return angle;
    endfunction

endpackage

`default_nettype wire
